//--- control_decode.sv
`timescale 1ns/1ps

module control_decode (
    input  logic   clk,
    input  logic   rst,
    pipe_link.down link_in,
    pipe_link.up   link_out
);

    import cpu_pkg::*;

    fetch_item_t item;
    op_sel_t     op;
    logic [3:0]  dev_field;
    logic        top_bit;
    logic        dev_top;
    logic        zp_store;
    ctrl_word_t  cw_next;
    ctrl_word_t  cw_q;
    logic        valid_q;

    assign item      = link_in.payload;
    assign op        = op_sel_t'(item.instr.hi[7:5]);
    assign dev_field = item.instr.hi[4:1];
    assign top_bit   = item.instr.hi[0];

    // the two stores into zero page take no device write
    assign zp_store = (op == OP_RAMZP_REG) || (op == OP_RAMZP_UART);

    ////////////////////////////////////////////////////////////
    // operation decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        // register X ops always land in A..P, non-register ops never do
        case (op)
            OP_REGX_ALU:   dev_top = 1'b1;
            OP_NONREG_ALU: dev_top = 1'b0;
            default:       dev_top = top_bit;
        endcase

        cw_next         = '0;
        cw_next.imm     = item.instr.lo;
        cw_next.pc      = item.pc;
        cw_next.alu_op  = ALU_PASS_X;
        cw_next.y_idx   = reg_idx_t'(item.instr.lo);
        cw_next.dev     = dev_sel_t'({dev_top, dev_field});
        cw_next.bus_src = SRC_ROM;

        case (op)
            OP_DEV_ROM: begin
                cw_next.bus_src = SRC_ROM;
            end
            OP_DEV_RAM: begin
                cw_next.bus_src = SRC_RAM;
            end
            OP_DEV_RAMZP: begin
                cw_next.bus_src = SRC_RAM;
                cw_next.zp      = 1'b1;
            end
            OP_DEV_UART: begin
                cw_next.bus_src = SRC_UART;
            end
            OP_REGX_ALU: begin
                cw_next.bus_src = SRC_ALU;
                cw_next.alu_op  = alu_op_t'(item.instr.lo[6:4]);
            end
            OP_NONREG_ALU: begin
                cw_next.bus_src      = SRC_ALU;
                cw_next.force_x_zero = 1'b1;
                cw_next.alu_op       = alu_op_t'(item.instr.lo[6:4]);
            end
            OP_RAMZP_REG: begin
                // device field names the register, X goes straight through
                cw_next.bus_src      = SRC_ALU;
                cw_next.zp           = 1'b1;
                cw_next.force_pass_x = 1'b1;
            end
            default: begin
                cw_next.bus_src = SRC_UART;
                cw_next.zp      = 1'b1;
            end
        endcase

        // no RAM write while RAM itself drives the bus
        cw_next.ram_wr = zp_store ||
                         (cw_next.dev == DEV_RAM && cw_next.bus_src != SRC_RAM);
        cw_next.reg_wr = dev_top && !zp_store;
    end

    ////////////////////////////////////////////////////////////
    // control word register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (link_out.flush) begin
            valid_q <= 1'b0;
        end else if (!link_out.hold) begin
            valid_q <= link_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!link_out.hold) begin
            cw_q <= cw_next;
        end
    end

    assign link_out.valid   = valid_q;
    assign link_out.payload = cw_q;

    // stall and flush pass on up to fetch
    assign link_in.hold  = link_out.hold;
    assign link_in.flush = link_out.flush;

endmodule

//--- cpu_core.f
+incdir+.
cpu_pkg.sv
pipe_link.sv
fetch_stage.sv
control_decode.sv
execute_stage.sv
cpu_core.sv
tb_cpu_core.sv

//--- cpu_core.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_core (
    input  logic                   clk,
    input  logic                   rst,
    output logic [`CPU_ROM_AW-1:0] rom_addr,
    input  cpu_pkg::instr_t        rom_data,
    output cpu_pkg::data_t         uart_tx_data,
    output logic                   uart_tx_valid,
    input  logic                   uart_tx_ready,
    input  cpu_pkg::data_t         uart_rx_data,
    input  logic                   uart_rx_valid,
    output logic                   uart_rx_ready
);

    import cpu_pkg::*;

    logic                   jump_taken;
    logic [`CPU_ROM_AW-1:0] jump_target;

    pipe_link #(.payload_t(fetch_item_t)) fetch_link ();
    pipe_link #(.payload_t(ctrl_word_t))  decode_link ();

    fetch_stage fetch_stage_i (
        .clk         (clk),
        .rst         (rst),
        .rom_addr    (rom_addr),
        .rom_data    (rom_data),
        .jump_taken  (jump_taken),
        .jump_target (jump_target),
        .link_out    (fetch_link.up)
    );

    control_decode control_decode_i (
        .clk      (clk),
        .rst      (rst),
        .link_in  (fetch_link.down),
        .link_out (decode_link.up)
    );

    execute_stage execute_stage_i (
        .clk           (clk),
        .rst           (rst),
        .link_in       (decode_link.down),
        .jump_taken    (jump_taken),
        .jump_target   (jump_target),
        .uart_tx_data  (uart_tx_data),
        .uart_tx_valid (uart_tx_valid),
        .uart_tx_ready (uart_tx_ready),
        .uart_rx_data  (uart_rx_data),
        .uart_rx_valid (uart_rx_valid),
        .uart_rx_ready (uart_rx_ready)
    );

endmodule

//--- cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath byte width
`define CPU_DATA_W 8

// program ROM address, PC high and low bytes
`define CPU_ROM_AW 16

// 1 KiB data RAM, low bits of the MAR pair
`define CPU_RAM_AW 10

// registers A to P
`define CPU_NUM_REGS 16

`endif

//--- cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

    localparam int REG_IW = $clog2(`CPU_NUM_REGS);

    typedef logic [`CPU_DATA_W-1:0] data_t;
    typedef logic [REG_IW-1:0] reg_idx_t;

    // high byte: op[7:5], device field[4:1], extra device bit[0]
    typedef struct packed {
        data_t hi;
        data_t lo;
    } instr_t;

    typedef enum logic [2:0] {
        OP_DEV_ROM    = 3'd0,
        OP_DEV_RAM    = 3'd1,
        OP_DEV_RAMZP  = 3'd2,
        OP_DEV_UART   = 3'd3,
        OP_REGX_ALU   = 3'd4,
        OP_NONREG_ALU = 3'd5,
        OP_RAMZP_REG  = 3'd6,
        OP_RAMZP_UART = 3'd7
    } op_sel_t;

    // 16..31 are registers A..P
    typedef enum logic [4:0] {
        DEV_RAM     = 5'd0,
        DEV_MARLO   = 5'd1,
        DEV_MARHI   = 5'd2,
        DEV_UART    = 5'd3,
        DEV_PCHITMP = 5'd4,
        DEV_PCLO    = 5'd5,
        DEV_PC      = 5'd6,
        DEV_JMPO    = 5'd7,
        DEV_JMPZ    = 5'd8,
        DEV_JMPC    = 5'd9,
        DEV_JMPDI   = 5'd10,
        DEV_JMPDO   = 5'd11,
        DEV_JMPEQ   = 5'd12,
        DEV_JMPNE   = 5'd13,
        DEV_JMPGT   = 5'd14,
        DEV_JMPLT   = 5'd15,
        DEV_REG_A   = 5'd16,
        DEV_REG_P   = 5'd31
    } dev_sel_t;

    typedef enum logic [2:0] {
        ALU_PASS_X = 3'd0,
        ALU_PASS_Y = 3'd1,
        ALU_ADD    = 3'd2,
        ALU_SUB    = 3'd3,
        ALU_AND    = 3'd4,
        ALU_OR     = 3'd5,
        ALU_XOR    = 3'd6,
        ALU_CMP    = 3'd7
    } alu_op_t;

    typedef enum logic [1:0] {
        SRC_ROM  = 2'd0,
        SRC_RAM  = 2'd1,
        SRC_UART = 2'd2,
        SRC_ALU  = 2'd3
    } bus_src_t;

    typedef struct packed {
        logic z;
        logic c;
        logic o;
        logic eq;
        logic ne;
        logic gt;
        logic lt;
    } flags_t;

    typedef struct packed {
        instr_t                 instr;
        logic [`CPU_ROM_AW-1:0] pc;
    } fetch_item_t;

    typedef struct packed {
        bus_src_t               bus_src;
        logic                   zp;
        logic                   force_x_zero;
        logic                   force_pass_x;
        alu_op_t                alu_op;
        dev_sel_t               dev;
        logic                   reg_wr;
        logic                   ram_wr;
        data_t                  imm;
        reg_idx_t               y_idx;
        logic [`CPU_ROM_AW-1:0] pc;
    } ctrl_word_t;

endpackage

//--- execute_stage.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module execute_stage (
    input  logic                   clk,
    input  logic                   rst,
    pipe_link.down                 link_in,
    output logic                   jump_taken,
    output logic [`CPU_ROM_AW-1:0] jump_target,
    output cpu_pkg::data_t         uart_tx_data,
    output logic                   uart_tx_valid,
    input  logic                   uart_tx_ready,
    input  cpu_pkg::data_t         uart_rx_data,
    input  logic                   uart_rx_valid,
    output logic                   uart_rx_ready
);

    import cpu_pkg::*;

    localparam int MSB = `CPU_DATA_W - 1;

    ctrl_word_t             cw;
    data_t                  regs [`CPU_NUM_REGS];
    data_t                  ram [2**`CPU_RAM_AW];
    data_t                  mar_lo, mar_hi, pc_hi_tmp;
    flags_t                 flags, alu_flags;
    logic [`CPU_RAM_AW-1:0] ram_addr;
    data_t                  x_val, y_val, alu_res, bus;
    alu_op_t                op_eff;
    logic [`CPU_DATA_W:0]   sum, diff;
    logic                   dev_wr, alu_upd, need_rx, need_tx, stall, commit, jump_cond;

    assign cw       = link_in.payload;
    assign dev_wr   = !cw.reg_wr && !cw.ram_wr;
    assign alu_upd  = (cw.bus_src == SRC_ALU) && !cw.force_pass_x;
    assign ram_addr = cw.zp ? `CPU_RAM_AW'(cw.imm) : `CPU_RAM_AW'({mar_hi, mar_lo});

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    always_comb begin
        x_val  = cw.force_x_zero ? '0 : regs[cw.dev[REG_IW-1:0]];
        y_val  = regs[cw.y_idx];
        op_eff = cw.force_pass_x ? ALU_PASS_X : cw.alu_op;
        sum    = {1'b0, x_val} + {1'b0, y_val};
        diff   = {1'b0, x_val} - {1'b0, y_val};
        alu_flags = '0;
        case (op_eff)
            ALU_PASS_Y: alu_res = y_val;
            ALU_ADD: begin
                alu_res     = sum[MSB:0];
                alu_flags.c = sum[`CPU_DATA_W];
                alu_flags.o = (x_val[MSB] == y_val[MSB]) && (alu_res[MSB] != x_val[MSB]);
            end
            ALU_SUB: begin
                // carry means no borrow
                alu_res     = diff[MSB:0];
                alu_flags.c = !diff[`CPU_DATA_W];
                alu_flags.o = (x_val[MSB] != y_val[MSB]) && (alu_res[MSB] != x_val[MSB]);
            end
            ALU_AND: alu_res = x_val & y_val;
            ALU_OR:  alu_res = x_val | y_val;
            ALU_XOR: alu_res = x_val ^ y_val;
            ALU_CMP: begin
                // X is left as it was
                alu_res     = x_val;
                alu_flags.c = !diff[`CPU_DATA_W];
            end
            default: alu_res = x_val;
        endcase
        alu_flags.z  = (alu_res == '0);
        alu_flags.eq = (x_val == y_val);
        alu_flags.ne = (x_val != y_val);
        alu_flags.gt = (x_val > y_val);
        alu_flags.lt = (x_val < y_val);
    end

    always_comb begin
        case (cw.bus_src)
            SRC_ROM:  bus = cw.imm;
            SRC_RAM:  bus = ram[ram_addr];
            SRC_UART: bus = uart_rx_data;
            default:  bus = alu_res;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // UART handshake and stall
    ////////////////////////////////////////////////////////////

    assign need_rx = link_in.valid && (cw.bus_src == SRC_UART);
    assign need_tx = link_in.valid && dev_wr && (cw.dev == DEV_UART);

    // an rx to tx copy moves both bytes on the same edge
    assign uart_rx_ready = need_rx && (!need_tx || uart_tx_ready);
    assign uart_tx_valid = need_tx && (!need_rx || uart_rx_valid);
    assign uart_tx_data  = bus;

    assign stall  = (need_rx && !uart_rx_valid) || (need_tx && !uart_tx_ready);
    assign commit = link_in.valid && !stall;

    assign link_in.hold  = stall;
    assign link_in.flush = jump_taken;

    // jump unit
    always_comb begin
        jump_cond   = 1'b0;
        jump_target = {pc_hi_tmp, bus};
        if (dev_wr) begin
            case (cw.dev)
                DEV_PCLO: begin
                    jump_cond   = 1'b1;
                    jump_target = {cw.pc[`CPU_ROM_AW-1:`CPU_DATA_W], bus};
                end
                DEV_PC:    jump_cond = 1'b1;
                DEV_JMPO:  jump_cond = flags.o;
                DEV_JMPZ:  jump_cond = flags.z;
                DEV_JMPC:  jump_cond = flags.c;
                DEV_JMPDI: jump_cond = uart_rx_valid;
                DEV_JMPDO: jump_cond = uart_tx_ready;
                DEV_JMPEQ: jump_cond = flags.eq;
                DEV_JMPNE: jump_cond = flags.ne;
                DEV_JMPGT: jump_cond = flags.gt;
                DEV_JMPLT: jump_cond = flags.lt;
                default:   jump_cond = 1'b0;
            endcase
        end
    end

    assign jump_taken = commit && jump_cond;

    ////////////////////////////////////////////////////////////
    // commit
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            mar_lo    <= '0;
            mar_hi    <= '0;
            pc_hi_tmp <= '0;
            flags     <= '0;
        end else if (commit) begin
            if (cw.reg_wr) begin
                regs[cw.dev[REG_IW-1:0]] <= bus;
            end
            if (alu_upd) begin
                flags <= alu_flags;
            end
            if (dev_wr) begin
                case (cw.dev)
                    DEV_MARLO:   mar_lo    <= bus;
                    DEV_MARHI:   mar_hi    <= bus;
                    DEV_PCHITMP: pc_hi_tmp <= bus;
                    default:     ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (commit && cw.ram_wr) begin
            ram[ram_addr] <= bus;
        end
    end

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module fetch_stage (
    input  logic                   clk,
    input  logic                   rst,
    output logic [`CPU_ROM_AW-1:0] rom_addr,
    input  cpu_pkg::instr_t        rom_data,
    input  logic                   jump_taken,
    input  logic [`CPU_ROM_AW-1:0] jump_target,
    pipe_link.up                   link_out
);

    import cpu_pkg::*;

    logic [`CPU_ROM_AW-1:0] pc;
    logic                   valid_q;
    fetch_item_t            item_q;

    // ROM answers in the same cycle
    assign rom_addr = pc;

    ////////////////////////////////////////////////////////////
    // program counter and slot valid
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= '0;
            valid_q <= 1'b0;
        end else begin
            // redirect wins over a held fetch
            if (jump_taken) begin
                pc <= jump_target;
            end else if (!link_out.hold) begin
                pc <= pc + 1'b1;
            end

            if (link_out.flush) begin
                valid_q <= 1'b0;
            end else if (!link_out.hold) begin
                valid_q <= 1'b1;
            end
        end
    end

    // instruction register, tagged with its own address
    always_ff @(posedge clk) begin
        if (!link_out.hold) begin
            item_q.instr <= rom_data;
            item_q.pc    <= pc;
        end
    end

    assign link_out.valid   = valid_q;
    assign link_out.payload = item_q;

endmodule

//--- pipe_link.sv
`timescale 1ns/1ps

// one pipeline slot between two stages
interface pipe_link #(
    parameter type payload_t = logic
);

    logic     valid;
    payload_t payload;

    // both come back from execute
    logic     hold;
    logic     flush;

    modport up (
        output valid,
        output payload,
        input  hold,
        input  flush
    );

    modport down (
        input  valid,
        input  payload,
        output hold,
        output flush
    );

endinterface

//--- tb_cpu_core.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tb_cpu_core;

    import cpu_pkg::*;

    localparam int RA = 0;
    localparam int RB = 1;
    localparam int RC = 2;
    localparam int RD = 3;
    localparam int RE = 4;
    localparam int RF = 5;
    localparam int RG = 6;
    localparam int RP = 15;

    logic                   clk = 1'b0;
    logic                   rst = 1'b1;
    logic [`CPU_ROM_AW-1:0] rom_addr;
    instr_t                 rom_data;
    data_t                  uart_tx_data;
    logic                   uart_tx_valid;
    logic                   uart_tx_ready = 1'b1;
    data_t                  uart_rx_data = '0;
    logic                   uart_rx_valid = 1'b0;
    logic                   uart_rx_ready;

    instr_t      rom [256];
    data_t       rx_q [$];
    data_t       tx_got [$];
    data_t       exp_q [$];
    int          prog_len;
    int          rx_gap;
    bit          rx_fire;
    bit          tx_random_en;
    bit          rx_delay_en;
    bit          tx_waiting = 1'b0;
    data_t       tx_held;
    string       test_name = "reset";
    integer      seed = 32'h6022_98ae;
    logic [31:0] rnd_drv;
    logic [31:0] rnd_main;
    int          budget_cycles = 64;
    int          cycles;
    int          byte_errors;
    int          count_errors;
    int          other_errors;

    cpu_core cpu_core_i (
        .clk           (clk),
        .rst           (rst),
        .rom_addr      (rom_addr),
        .rom_data      (rom_data),
        .uart_tx_data  (uart_tx_data),
        .uart_tx_valid (uart_tx_valid),
        .uart_tx_ready (uart_tx_ready),
        .uart_rx_data  (uart_rx_data),
        .uart_rx_valid (uart_rx_valid),
        .uart_rx_ready (uart_rx_ready)
    );

    always #20 clk = ~clk;

    // combinational program ROM
    assign rom_data = rom[rom_addr[7:0]];

    ////////////////////////////////////////////////////////////
    // UART models
    ////////////////////////////////////////////////////////////

    // handshakes are decided by the values held over the next edge
    always @(negedge clk) begin
        rx_fire = (uart_rx_valid === 1'b1) && (uart_rx_ready === 1'b1);
        // a byte left waiting must stay offered and unchanged
        if (tx_waiting) begin
            if (uart_tx_valid !== 1'b1) begin
                other_errors++;
                $display("%s: uart_tx_valid dropped before the byte was taken", test_name);
            end else begin
                check_byte("uart_tx_data held", uart_tx_data, tx_held);
            end
        end
        tx_waiting = (uart_tx_valid === 1'b1) && (uart_tx_ready !== 1'b1);
        tx_held    = uart_tx_data;
        if ((uart_tx_valid === 1'b1) && (uart_tx_ready === 1'b1)) begin
            tx_got.push_back(uart_tx_data);
        end
    end

    always @(posedge clk) begin
        #1;
        if (rx_fire) begin
            rx_q.delete(0);
            if (rx_delay_en) begin
                rnd_drv = $random(seed);
                rx_gap  = rnd_drv[1:0];
            end
        end
        if (rx_gap > 0) begin
            rx_gap--;
            uart_rx_valid = 1'b0;
        end else if (rx_q.size() > 0) begin
            uart_rx_valid = 1'b1;
            uart_rx_data  = rx_q[0];
        end else begin
            uart_rx_valid = 1'b0;
        end
        if (tx_random_en) begin
            rnd_drv       = $random(seed);
            uart_tx_ready = rnd_drv[0];
        end else begin
            uart_tx_ready = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // instruction encoding and program building
    ////////////////////////////////////////////////////////////

    // high byte is op, device field, then the top device bit
    function automatic instr_t encode(input op_sel_t op, input logic [4:0] dev,
                                      input data_t lo);
        instr_t ins;
        ins.hi = {op, dev[3:0], dev[4]};
        ins.lo = lo;
        return ins;
    endfunction

    function automatic logic [4:0] reg_dev(input int r);
        return 5'(16 + r);
    endfunction

    // signed result out of the byte range
    function automatic bit add_overflow(input data_t x, input data_t y);
        int s;
        s = int'($signed(x)) + int'($signed(y));
        return (s > 127) || (s < -128);
    endfunction

    task automatic emit(input instr_t ins);
        rom[prog_len] = ins;
        prog_len++;
    endtask

    task automatic load_reg(input int r, input data_t v);
        emit(encode(OP_DEV_ROM, reg_dev(r), v));
    endtask

    task automatic send_reg(input int r);
        emit(encode(OP_NONREG_ALU, DEV_UART, {1'b0, ALU_PASS_Y, 4'(r)}));
    endtask

    task automatic send_imm(input data_t v);
        emit(encode(OP_DEV_ROM, DEV_UART, v));
    endtask

    task automatic alu_to_reg(input int x, input alu_op_t op, input int y);
        emit(encode(OP_REGX_ALU, reg_dev(x), {1'b0, op, 4'(y)}));
    endtask

    // taken path sends A<id> and fall-through sends 5<id>
    task automatic branch(input logic [4:0] dev, input logic [3:0] id, input bit taken);
        int k;
        k = prog_len;
        emit(encode(OP_DEV_ROM, dev, 8'(k + 3)));
        send_imm({4'h5, id});
        emit(encode(OP_DEV_ROM, DEV_PC, 8'(k + 4)));
        send_imm({4'hA, id});
        exp_q.push_back(taken ? {4'hA, id} : {4'h5, id});
    endtask

    ////////////////////////////////////////////////////////////
    // checks and test sequencing
    ////////////////////////////////////////////////////////////

    task automatic check_byte(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            byte_errors++;
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_tx_count(input int got, input int exp);
        if (got != exp) begin
            count_errors++;
            $display("MISMATCH uart_tx byte count: got 0x%0h expected 0x%0h", got, exp);
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d byte mismatches, %0d count mismatches, %0d other",
                 byte_errors, count_errors, other_errors);
    endtask

    task automatic begin_test(input string name);
        @(negedge clk);
        tx_random_en = 1'b0;
        rx_delay_en  = 1'b0;
        rx_gap       = 0;
        @(posedge clk);
        #1;
        rst       = 1'b1;
        test_name = name;
        // every unused word is a jump to itself
        for (int i = 0; i < 256; i++) begin
            rom[i] = encode(OP_DEV_ROM, DEV_PC, 8'(i));
        end
        prog_len = 0;
        rx_q.delete();
        tx_got.delete();
        exp_q.delete();
        $display("test %s", name);
    endtask

    // halt reached twice means the halt itself executed
    task automatic wait_halt(input int addr);
        while (rom_addr !== 16'(addr)) @(negedge clk);
        while (rom_addr === 16'(addr)) @(negedge clk);
        while (rom_addr !== 16'(addr)) @(negedge clk);
    endtask

    task automatic run_program(input bit rand_uart);
        int halt_at;
        int n;
        // two trailing markers keep the last jump ahead of the halt
        send_imm(8'hEE);
        exp_q.push_back(8'hEE);
        send_imm(8'hEF);
        exp_q.push_back(8'hEF);
        halt_at = prog_len;
        emit(encode(OP_DEV_ROM, DEV_PC, 8'(halt_at)));
        budget_cycles += 20 * prog_len + 40;
        @(negedge clk);
        tx_random_en = rand_uart;
        rx_delay_en  = rand_uart;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        wait_halt(halt_at);
        check_tx_count(tx_got.size(), exp_q.size());
        n = (tx_got.size() < exp_q.size()) ? tx_got.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            check_byte($sformatf("uart_tx_data[%0d]", i), tx_got[i], exp_q[i]);
        end
        if (rx_q.size() != 0) begin
            other_errors++;
            $display("%s: %0d UART input bytes were never read", test_name, rx_q.size());
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_moves();
        begin_test("moves");
        load_reg(RA, 8'h3C);
        load_reg(RB, 8'hA5);
        load_reg(RC, 8'h00);
        load_reg(RP, 8'h7E);
        alu_to_reg(RD, ALU_PASS_Y, RB);
        send_reg(RA);
        send_reg(RB);
        send_reg(RC);
        send_reg(RP);
        send_reg(RD);
        send_imm(8'h5A);
        exp_q = '{8'h3C, 8'hA5, 8'h00, 8'h7E, 8'hA5, 8'h5A};
        run_program(1'b0);
    endtask

    task automatic alu_case(input int r, input alu_op_t op, input data_t x,
                            input data_t expected);
        load_reg(r, x);
        alu_to_reg(r, op, RB);
        send_reg(r);
        exp_q.push_back(expected);
    endtask

    task automatic test_alu(input data_t x, input data_t y);
        data_t e;
        begin_test($sformatf("alu %h %h", x, y));
        load_reg(RB, y);
        e = x + y;
        alu_case(RC, ALU_ADD, x, e);
        e = x - y;
        alu_case(RD, ALU_SUB, x, e);
        alu_case(RE, ALU_AND, x, x & y);
        alu_case(RF, ALU_OR, x, x | y);
        alu_case(RG, ALU_XOR, x, x ^ y);
        run_program(1'b0);
    endtask

    task automatic test_memory();
        begin_test("memory");
        load_reg(RA, 8'h96);
        load_reg(RB, 8'h11);
        emit(encode(OP_RAMZP_REG, reg_dev(RA), 8'h21));
        emit(encode(OP_DEV_RAMZP, reg_dev(RB), 8'h21));
        send_reg(RB);
        emit(encode(OP_DEV_RAMZP, DEV_UART, 8'h21));
        // MAR points at 0x37f so zero page 0x7f must stay separate
        emit(encode(OP_DEV_ROM, DEV_MARHI, 8'h03));
        emit(encode(OP_DEV_ROM, DEV_MARLO, 8'h7F));
        emit(encode(OP_DEV_ROM, DEV_RAM, 8'hC3));
        emit(encode(OP_RAMZP_REG, reg_dev(RA), 8'h7F));
        emit(encode(OP_DEV_RAM, reg_dev(RC), 8'h00));
        send_reg(RC);
        emit(encode(OP_DEV_RAMZP, DEV_UART, 8'h7F));
        exp_q = '{8'h96, 8'h96, 8'hC3, 8'h96};
        run_program(1'b0);
    endtask

    task automatic test_uart_stream();
        data_t b;
        begin_test("uart stream");
        for (int i = 0; i < 6; i++) begin
            rnd_main = $random(seed);
            b        = rnd_main[7:0];
            rx_q.push_back(b);
            exp_q.push_back(b);
        end
        emit(encode(OP_DEV_UART, DEV_UART, 8'h00));
        emit(encode(OP_DEV_UART, DEV_UART, 8'h00));
        emit(encode(OP_RAMZP_UART, DEV_RAM, 8'h40));
        emit(encode(OP_RAMZP_UART, DEV_RAM, 8'h41));
        emit(encode(OP_DEV_UART, reg_dev(RD), 8'h00));
        emit(encode(OP_DEV_RAMZP, DEV_UART, 8'h40));
        emit(encode(OP_DEV_RAMZP, DEV_UART, 8'h41));
        send_reg(RD);
        emit(encode(OP_DEV_UART, DEV_UART, 8'h00));
        run_program(1'b1);
    endtask

    task automatic test_jumps();
        data_t a;
        data_t b;
        data_t c;
        data_t d;
        data_t e;
        data_t f;
        int    s1;
        int    s2;
        a  = 8'h40;
        b  = 8'h30;
        c  = 8'hF0;
        d  = 8'h10;
        e  = 8'h70;
        f  = 8'h20;
        s1 = int'(c) + int'(d);
        s2 = int'(e) + int'(f);
        begin_test("jumps");
        rx_q.push_back(8'h3D);
        load_reg(RA, a);
        load_reg(RB, b);
        alu_to_reg(RA, ALU_CMP, RB);
        branch(DEV_JMPGT, 4'd1, a > b);
        branch(DEV_JMPLT, 4'd2, a < b);
        branch(DEV_JMPEQ, 4'd3, a == b);
        branch(DEV_JMPNE, 4'd4, a != b);
        alu_to_reg(RB, ALU_CMP, RA);
        branch(DEV_JMPLT, 4'd5, b < a);
        load_reg(RC, c);
        load_reg(RD, d);
        alu_to_reg(RC, ALU_ADD, RD);
        branch(DEV_JMPZ, 4'd6, (s1 % 256) == 0);
        branch(DEV_JMPC, 4'd7, s1 > 255);
        branch(DEV_JMPO, 4'd8, add_overflow(c, d));
        load_reg(RE, e);
        load_reg(RF, f);
        alu_to_reg(RE, ALU_ADD, RF);
        branch(DEV_JMPO, 4'd9, add_overflow(e, f));
        branch(DEV_JMPZ, 4'd10, (s2 % 256) == 0);
        branch(DEV_JMPC, 4'd11, s2 > 255);
        // rx holds one byte until the read below empties it
        branch(DEV_JMPDI, 4'd12, 1'b1);
        emit(encode(OP_DEV_UART, reg_dev(RG), 8'h00));
        branch(DEV_JMPDI, 4'd13, 1'b0);
        send_reg(RG);
        exp_q.push_back(8'h3D);
        branch(DEV_JMPDO, 4'd14, 1'b1);
        branch(DEV_PCLO, 4'd0, 1'b1);
        run_program(1'b0);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        test_moves();
        test_alu(8'hC8, 8'h5B);
        rnd_main = $random(seed);
        test_alu(rnd_main[7:0], rnd_main[15:8]);
        test_memory();
        test_uart_stream();
        test_jumps();
        print_counts();
        if (byte_errors + count_errors + other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // budget grows by 20 cycles per instruction as each test loads
    initial begin
        cycles = 0;
        while (cycles <= budget_cycles) begin
            @(posedge clk);
            cycles++;
        end
        other_errors++;
        $display("watchdog expired after %0d cycles in test %s", cycles, test_name);
        print_counts();
        $display("=== FAIL ===");
        $finish;
    end

endmodule
